/* dv/tb_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        dmem_req,
    input  logic        dmem_we,
    input  logic [31:0] dmem_addr,
    input  logic [31:0] dmem_wdata,
    output logic        done,
    output int          pass_count,
    output int          fail_count
);

    // Result word address watched by every test
    localparam logic [31:0] result_addr = 32'h0000_0100;

    string       cur_name;
    logic [31:0] cur_expected;
    int          cur_prior;
    int          store_count;
    int          cycles_out_of_reset;
    logic        armed;

    initial begin
        done                = 1'b0;
        armed               = 1'b0;
        pass_count          = 0;
        fail_count          = 0;
        store_count         = 0;
        cur_prior           = 0;
        cycles_out_of_reset = 0;
        cur_expected        = '0;
    end

    // Called by the testbench before each reset release
    task automatic arm(input string name, input logic [31:0] expected, input int prior);
        cur_name     = name;
        cur_expected = expected;
        cur_prior    = prior;
        store_count  = 0;
        done         = 1'b0;
        armed        = 1'b1;
    endtask

    always @(posedge clk) begin
        if (!arst_n || cycles_out_of_reset < 3) begin
            // No instruction can reach MEM this early
            if (dmem_req && dmem_we) begin
                $display("%s: data-memory write to 0x%08h during or right after reset",
                         cur_name, dmem_addr);
                fail_count++;
            end
            if (!arst_n) begin
                cycles_out_of_reset = 0;
            end else begin
                cycles_out_of_reset++;
            end
        end else if (dmem_req && dmem_we && armed) begin
            if (dmem_addr != result_addr) begin
                store_count++;
            end else begin
                if (dmem_wdata !== cur_expected) begin
                    $display("[ERROR] %s: expected 0x%08h, actual 0x%08h",
                             cur_name, cur_expected, dmem_wdata);
                    fail_count++;
                end else if (store_count != cur_prior) begin
                    $display("%s: made %0d stores before the result instead of %0d",
                             cur_name, store_count, cur_prior);
                    fail_count++;
                end else begin
                    $display("%s: ok, result 0x%08h", cur_name, dmem_wdata);
                    pass_count++;
                end
                done  = 1'b1;
                armed = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_top;

    localparam int n_tests   = 5;
    localparam int max_wait  = 200;

    logic        clk;
    logic        arst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        dmem_req;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        check_done;
    int          pass_count;
    int          fail_count;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    // Test table
    string       test_name    [n_tests];
    logic [31:0] prog         [n_tests][16];
    logic [31:0] expected     [n_tests];
    int          prior_stores [n_tests];

    rv_core_top rv_core_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    tb_checker tb_checker_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .done       (check_done),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    // Word-addressed memories, both answer in the same cycle
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_req && dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // RV32I encodings
    function automatic logic [31:0] rop(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iop(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic build_tests();
        logic [11:0] imm1;
        logic [11:0] imm2;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] r5;
        logic [31:0] r6;
        logic [31:0] r7;
        logic [31:0] r8;
        logic [31:0] r9;
        logic [31:0] hi1;
        logic [31:0] hi2;
        for (int t = 0; t < n_tests; t++) begin
            for (int i = 0; i < 16; i++) begin
                prog[t][i] = iop(3'b000, 5'd0, 5'd0, 12'd0);
            end
        end

        // ALU chain with random immediates
        imm1 = 12'($urandom);
        imm2 = 12'($urandom);
        a  = {{20{imm1[11]}}, imm1};
        b  = {{20{imm2[11]}}, imm2};
        r3 = a + b;
        r4 = r3 - a;
        r5 = r4 & r3;
        r6 = r5 | b;
        r7 = r6 ^ r4;
        r8 = ($signed(r7) < $signed(r3)) ? 32'd1 : 32'd0;
        r9 = ($signed(r7) < $signed(a)) ? 32'd1 : 32'd0;
        test_name[0]    = "alu_chain";
        prog[0][0]      = iop(3'b000, 5'd1, 5'd0, imm1);
        prog[0][1]      = iop(3'b000, 5'd2, 5'd0, imm2);
        prog[0][2]      = rop(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
        prog[0][3]      = rop(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);
        prog[0][4]      = rop(7'h00, 3'b111, 5'd5, 5'd4, 5'd3);
        prog[0][5]      = rop(7'h00, 3'b110, 5'd6, 5'd5, 5'd2);
        prog[0][6]      = rop(7'h00, 3'b100, 5'd7, 5'd6, 5'd4);
        prog[0][7]      = rop(7'h00, 3'b010, 5'd8, 5'd7, 5'd3);
        prog[0][8]      = iop(3'b010, 5'd9, 5'd7, imm1);
        prog[0][9]      = rop(7'h00, 3'b000, 5'd10, 5'd7, 5'd8);
        prog[0][10]     = rop(7'h00, 3'b000, 5'd10, 5'd10, 5'd9);
        prog[0][11]     = store_word(5'd10, 5'd0, 12'h100);
        prog[0][12]     = jal_word(5'd0, 21'd0);
        expected[0]     = r7 + r8 + r9;
        prior_stores[0] = 0;

        // Load-use pair, then a load with one independent instruction between
        test_name[1]    = "load_use";
        prog[1][0]      = iop(3'b000, 5'd1, 5'd0, 12'h123);
        prog[1][1]      = store_word(5'd1, 5'd0, 12'h040);
        prog[1][2]      = load_word(5'd2, 5'd0, 12'h040);
        prog[1][3]      = rop(7'h00, 3'b000, 5'd1, 5'd2, 5'd1);
        prog[1][4]      = load_word(5'd4, 5'd0, 12'h040);
        prog[1][5]      = iop(3'b000, 5'd5, 5'd0, 12'd7);
        prog[1][6]      = rop(7'h00, 3'b000, 5'd6, 5'd4, 5'd5);
        prog[1][7]      = rop(7'h00, 3'b000, 5'd7, 5'd1, 5'd6);
        prog[1][8]      = store_word(5'd7, 5'd0, 12'h100);
        prog[1][9]      = jal_word(5'd0, 21'd0);
        expected[1]     = (32'h123 + 32'h123) + (32'h123 + 32'd7);
        prior_stores[1] = 1;

        // Taken BEQ and JAL skip two writes each, BNE falls through
        test_name[2]    = "branch_squash";
        prog[2][0]      = iop(3'b000, 5'd1, 5'd0, 12'd11);
        prog[2][1]      = iop(3'b000, 5'd2, 5'd0, 12'd11);
        prog[2][2]      = branch_word(3'b000, 5'd1, 5'd2, 13'd12);
        prog[2][3]      = iop(3'b000, 5'd1, 5'd0, 12'd99);
        prog[2][4]      = iop(3'b000, 5'd1, 5'd0, 12'd98);
        prog[2][5]      = branch_word(3'b001, 5'd1, 5'd2, 13'd8);
        prog[2][6]      = iop(3'b000, 5'd3, 5'd1, 12'd4);
        prog[2][7]      = jal_word(5'd5, 21'd12);
        prog[2][8]      = iop(3'b000, 5'd3, 5'd0, 12'd77);
        prog[2][9]      = iop(3'b000, 5'd3, 5'd0, 12'd76);
        prog[2][10]     = rop(7'h00, 3'b000, 5'd3, 5'd3, 5'd5);
        prog[2][11]     = rop(7'h00, 3'b000, 5'd3, 5'd3, 5'd1);
        prog[2][12]     = store_word(5'd3, 5'd0, 12'h100);
        prog[2][13]     = jal_word(5'd0, 21'd0);
        // x3 = 11 + 4, x5 = PC of the JAL plus 4
        expected[2]     = (32'd11 + 32'd4) + (32'd28 + 32'd4) + 32'd11;
        prior_stores[2] = 0;

        // Full constants, one with a negative low part
        hi1 = {20'h12345, 12'h000};
        hi2 = {20'habcdf, 12'h000};
        test_name[3]    = "lui_addi";
        prog[3][0]      = lui_word(5'd1, 20'h12345);
        prog[3][1]      = iop(3'b000, 5'd1, 5'd1, 12'h678);
        prog[3][2]      = lui_word(5'd2, 20'habcdf);
        prog[3][3]      = iop(3'b000, 5'd2, 5'd2, 12'hdef);
        prog[3][4]      = rop(7'h00, 3'b100, 5'd3, 5'd1, 5'd2);
        prog[3][5]      = store_word(5'd3, 5'd0, 12'h100);
        prog[3][6]      = jal_word(5'd0, 21'd0);
        expected[3]     = (hi1 + 32'h0000_0678) ^ (hi2 + 32'hffff_fdef);
        prior_stores[3] = 0;

        test_name[4]    = "x0_discard";
        prog[4][0]      = iop(3'b000, 5'd0, 5'd0, 12'd55);
        prog[4][1]      = iop(3'b000, 5'd1, 5'd0, 12'd9);
        prog[4][2]      = rop(7'h00, 3'b000, 5'd2, 5'd0, 5'd1);
        prog[4][3]      = rop(7'h00, 3'b000, 5'd0, 5'd1, 5'd1);
        prog[4][4]      = rop(7'h00, 3'b000, 5'd3, 5'd2, 5'd0);
        prog[4][5]      = store_word(5'd3, 5'd0, 12'h080);
        prog[4][6]      = store_word(5'd3, 5'd0, 12'h100);
        prog[4][7]      = jal_word(5'd0, 21'd0);
        expected[4]     = 32'd9;
        prior_stores[4] = 1;
    endtask

    // Reset held for 4 cycles while the memories are reloaded
    task automatic reset_and_load(input int t);
        @(negedge clk);
        arst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < 16) ? prog[t][i] : iop(3'b000, 5'd0, 5'd0, 12'd0);
            dmem[i] = {8'(i), 8'(~i), 8'(i), 8'hc3};
        end
        tb_checker_inst.arm(test_name[t], expected[t], prior_stores[t]);
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
    endtask

    initial begin
        int cycles;
        int timeouts;
        arst_n   = 1'b0;
        timeouts = 0;
        void'($urandom(32'h14b1_ce3a));
        build_tests();
        for (int i = 0; i < 256; i++) begin
            imem[i] = iop(3'b000, 5'd0, 5'd0, 12'd0);
            dmem[i] = {8'(i), 8'(~i), 8'(i), 8'hc3};
        end

        for (int t = 0; t < n_tests; t++) begin
            reset_and_load(t);
            cycles = 0;
            while (!check_done && cycles < max_wait) begin
                @(negedge clk);
                cycles++;
            end
            if (!check_done) begin
                $display("%s: no store to 0x100 within %0d cycles", test_name[t], max_wait);
                timeouts++;
            end
        end

        $display("tests %0d, passed %0d, failed %0d, timed out %0d",
                 n_tests, pass_count, fail_count, timeouts);
        if (fail_count == 0 && timeouts == 0 && pass_count == n_tests) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          stall,
    input  logic                          flush,
    input  logic [rv_pkg::xlen-1:0]       id_pc,
    input  logic [rv_pkg::xlen-1:0]       id_instr,
    input  rv_pkg::fwd_sel_e              fwd_a,
    input  rv_pkg::fwd_sel_e              fwd_b,
    input  logic [rv_pkg::xlen-1:0]       rf_rdata1,
    input  logic [rv_pkg::xlen-1:0]       rf_rdata2,
    output logic [rv_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::xlen-1:0]       ex_pc,
    output logic [rv_pkg::xlen-1:0]       ex_a,
    output logic [rv_pkg::xlen-1:0]       ex_b,
    output logic [rv_pkg::xlen-1:0]       ex_imm,
    output logic [rv_pkg::reg_addr_w-1:0] ex_rd,
    output rv_pkg::alu_op_e               ex_alu_op,
    output rv_pkg::opcode_e               ex_opcode,
    output rv_pkg::wb_sel_e               ex_wb_sel,
    output logic                          ex_wr_en,
    output logic                          ex_use_imm,
    output logic [rv_pkg::xlen-1:0]       ex_store_data,
    hazard_if.sink                        haz
);
    import rv_pkg::*;

    logic [2:0]      funct3;
    opcode_e         opcode;
    opcode_e         d_opcode;
    alu_op_e         d_alu_op;
    wb_sel_e         d_wb_sel;
    logic            d_wr_en;
    logic            d_use_imm;
    logic [xlen-1:0] d_imm;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;

    // Shared funct3 map of R-type and I-type ALU ops
    function automatic alu_op_e alu_of(input logic [2:0] f3);
        case (f3)
            3'b010:  return alu_slt;
            3'b100:  return alu_xor;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    assign rs1    = id_instr[19:15];
    assign rs2    = id_instr[24:20];
    assign funct3 = id_instr[14:12];
    assign opcode = opcode_e'(id_instr[6:0]);

    always_comb begin
        d_opcode  = opcode;
        d_alu_op  = alu_add;
        d_wb_sel  = wb_alu;
        d_wr_en   = 1'b0;
        d_use_imm = 1'b1;
        d_imm     = {{20{id_instr[31]}}, id_instr[31:20]};
        case (opcode)
            op_rtype: begin
                d_use_imm = 1'b0;
                d_wr_en   = 1'b1;
                d_alu_op  = (funct3 == 3'b000 && id_instr[30]) ? alu_sub : alu_of(funct3);
            end
            op_itype: begin
                d_wr_en  = 1'b1;
                d_alu_op = alu_of(funct3);
            end
            op_lui: begin
                d_wr_en  = 1'b1;
                d_alu_op = alu_pass_b;
                d_imm    = {id_instr[31:12], 12'b0};
            end
            op_load: begin
                d_wr_en  = 1'b1;
                d_wb_sel = wb_mem;
            end
            op_store: begin
                d_imm = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
            end
            op_branch: begin
                // BNE is flagged to execute as alu_xor, BEQ as alu_sub
                d_use_imm = 1'b0;
                d_alu_op  = funct3[0] ? alu_xor : alu_sub;
                d_imm     = {{19{id_instr[31]}}, id_instr[31], id_instr[7],
                             id_instr[30:25], id_instr[11:8], 1'b0};
            end
            op_jal: begin
                d_wr_en  = 1'b1;
                d_wb_sel = wb_pc4;
                d_imm    = {{11{id_instr[31]}}, id_instr[31], id_instr[19:12],
                            id_instr[20], id_instr[30:21], 1'b0};
            end
            // Unsupported encodings run as bubbles
            default: d_opcode = op_itype;
        endcase
    end

    // Operand forwarding
    assign op_a = (fwd_a == fwd_ex)  ? haz.ex_result :
                  (fwd_a == fwd_mem) ? haz.mem_result : rf_rdata1;
    assign op_b = (fwd_b == fwd_ex)  ? haz.ex_result :
                  (fwd_b == fwd_mem) ? haz.mem_result : rf_rdata2;

    // ID/EX control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_opcode  <= op_itype;
            ex_alu_op  <= alu_add;
            ex_wb_sel  <= wb_alu;
            ex_wr_en   <= 1'b0;
            ex_use_imm <= 1'b1;
            ex_rd      <= '0;
        end else if (stall || flush) begin
            ex_opcode  <= op_itype;
            ex_alu_op  <= alu_add;
            ex_wb_sel  <= wb_alu;
            ex_wr_en   <= 1'b0;
            ex_use_imm <= 1'b1;
            ex_rd      <= '0;
        end else begin
            ex_opcode  <= d_opcode;
            ex_alu_op  <= d_alu_op;
            ex_wb_sel  <= d_wb_sel;
            ex_wr_en   <= d_wr_en;
            ex_use_imm <= d_use_imm;
            ex_rd      <= id_instr[11:7];
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        ex_pc         <= id_pc;
        ex_a          <= op_a;
        ex_b          <= op_b;
        ex_imm        <= d_imm;
        ex_store_data <= op_b;
    end

endmodule

`default_nettype wire

/* src/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [rv_pkg::xlen-1:0]       ex_pc,
    input  logic [rv_pkg::xlen-1:0]       ex_a,
    input  logic [rv_pkg::xlen-1:0]       ex_b,
    input  logic [rv_pkg::xlen-1:0]       ex_imm,
    input  logic [rv_pkg::reg_addr_w-1:0] ex_rd,
    input  rv_pkg::alu_op_e               ex_alu_op,
    input  rv_pkg::opcode_e               ex_opcode,
    input  rv_pkg::wb_sel_e               ex_wb_sel,
    input  logic                          ex_wr_en,
    input  logic                          ex_use_imm,
    input  logic [rv_pkg::xlen-1:0]       ex_store_data,
    output logic                          take_branch,
    output logic [rv_pkg::xlen-1:0]       branch_target,
    output logic [rv_pkg::xlen-1:0]       mem_result_alu,
    output logic [rv_pkg::xlen-1:0]       mem_store_data,
    output logic [rv_pkg::reg_addr_w-1:0] mem_rd,
    output rv_pkg::opcode_e               mem_opcode,
    output rv_pkg::wb_sel_e               mem_wb_sel,
    output logic                          mem_wr_en,
    output logic [rv_pkg::xlen-1:0]       mem_pc4,
    hazard_if.ex_src                      haz
);
    import rv_pkg::*;

    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_y;
    logic [xlen-1:0] pc4;
    logic            eq;

    assign alu_b = ex_use_imm ? ex_imm : ex_b;

    always_comb begin
        case (ex_alu_op)
            alu_sub:    alu_y = ex_a - alu_b;
            alu_and:    alu_y = ex_a & alu_b;
            alu_or:     alu_y = ex_a | alu_b;
            alu_xor:    alu_y = ex_a ^ alu_b;
            alu_slt:    alu_y = {{(xlen-1){1'b0}}, $signed(ex_a) < $signed(alu_b)};
            alu_pass_b: alu_y = alu_b;
            default:    alu_y = ex_a + alu_b;
        endcase
    end

    assign pc4 = ex_pc + xlen'(4);
    assign eq  = (ex_a == ex_b);

    // Branch resolution, BNE carries alu_xor
    always_comb begin
        case (ex_opcode)
            op_jal:    take_branch = 1'b1;
            op_branch: take_branch = (ex_alu_op == alu_xor) ? !eq : eq;
            default:   take_branch = 1'b0;
        endcase
    end

    assign branch_target = ex_pc + ex_imm;

    assign haz.ex_rd      = ex_rd;
    assign haz.ex_wr_en   = ex_wr_en;
    assign haz.ex_is_load = (ex_opcode == op_load);
    assign haz.ex_result  = (ex_wb_sel == wb_pc4) ? pc4 : alu_y;

    // EX/MEM control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_opcode <= op_itype;
            mem_wb_sel <= wb_alu;
            mem_wr_en  <= 1'b0;
            mem_rd     <= '0;
        end else begin
            mem_opcode <= ex_opcode;
            mem_wb_sel <= ex_wb_sel;
            mem_wr_en  <= ex_wr_en;
            mem_rd     <= ex_rd;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        mem_result_alu <= alu_y;
        mem_store_data <= ex_store_data;
        mem_pc4        <= pc4;
    end

    // ID/EX resets to a bubble, so no redirect while in reset
    a_no_branch_in_reset: assert property (
        @(posedge clk) !arst_n |-> !take_branch
    );

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    take_branch,
    input  logic [rv_pkg::xlen-1:0] branch_target,
    input  logic [rv_pkg::xlen-1:0] imem_data,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    output logic [rv_pkg::xlen-1:0] id_pc,
    output logic [rv_pkg::xlen-1:0] id_instr
);
    import rv_pkg::*;

    logic [xlen-1:0] pc;

    // Redirect from EX wins over a load-use hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (take_branch) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc + xlen'(4);
        end
    end

    assign imem_addr = pc;

    // IF/ID instruction, squashed to a NOP on flush
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_instr <= nop_instr;
        end else if (flush) begin
            id_instr <= nop_instr;
        end else if (!stall) begin
            id_instr <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc <= pc;
        end
    end

    // Hazard unit must let a flush override the stall
    a_no_stall_on_flush: assert property (
        @(posedge clk) disable iff (!arst_n) !(stall && flush)
    );

endmodule

`default_nettype wire

/* src/hazard_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface hazard_if;
    import rv_pkg::*;

    // Instruction currently in EX
    logic [reg_addr_w-1:0] ex_rd;
    logic                  ex_wr_en;
    logic                  ex_is_load;
    logic [xlen-1:0]       ex_result;

    // Instruction currently in MEM
    logic [reg_addr_w-1:0] mem_rd;
    logic                  mem_wr_en;
    logic [xlen-1:0]       mem_result;

    modport ex_src (output ex_rd, ex_wr_en, ex_is_load, ex_result);
    modport mem_src (output mem_rd, mem_wr_en, mem_result);
    modport sink (
        input ex_rd, ex_wr_en, ex_is_load, ex_result,
        input mem_rd, mem_wr_en, mem_result
    );

endinterface

`default_nettype wire

/* src/hazard_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    input  rv_pkg::opcode_e               id_opcode,
    input  logic                          take_branch,
    hazard_if.sink                        haz,
    output rv_pkg::fwd_sel_e              fwd_a,
    output rv_pkg::fwd_sel_e              fwd_b,
    output logic                          stall,
    output logic                          flush
);
    import rv_pkg::*;

    logic use_rs1;
    logic use_rs2;
    logic load_use;

    // Youngest producer wins, x0 never forwarded
    function automatic fwd_sel_e pick_fwd(
        input logic [reg_addr_w-1:0] rs,
        input logic [reg_addr_w-1:0] ex_rd,
        input logic                  ex_wr_en,
        input logic [reg_addr_w-1:0] mem_rd,
        input logic                  mem_wr_en
    );
        if (rs == '0) return fwd_none;
        if (ex_wr_en && ex_rd == rs) return fwd_ex;
        if (mem_wr_en && mem_rd == rs) return fwd_mem;
        return fwd_none;
    endfunction

    // Source registers actually read by the ID instruction
    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (id_opcode)
            op_rtype, op_store, op_branch: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            op_itype, op_load: use_rs1 = 1'b1;
            default: ;
        endcase
    end

    assign fwd_a = pick_fwd(rs1, haz.ex_rd, haz.ex_wr_en, haz.mem_rd, haz.mem_wr_en);
    assign fwd_b = pick_fwd(rs2, haz.ex_rd, haz.ex_wr_en, haz.mem_rd, haz.mem_wr_en);

    // Load data only exists once the load reaches MEM
    assign load_use = haz.ex_is_load && haz.ex_wr_en && haz.ex_rd != '0 &&
                      ((use_rs1 && haz.ex_rd == rs1) || (use_rs2 && haz.ex_rd == rs2));

    assign flush = take_branch;
    assign stall = load_use && !take_branch;

endmodule

`default_nettype wire

/* src/mem_wb_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_wb_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [rv_pkg::xlen-1:0]       mem_result_alu,
    input  logic [rv_pkg::xlen-1:0]       mem_store_data,
    input  logic [rv_pkg::reg_addr_w-1:0] mem_rd,
    input  rv_pkg::opcode_e               mem_opcode,
    input  rv_pkg::wb_sel_e               mem_wb_sel,
    input  logic                          mem_wr_en,
    input  logic [rv_pkg::xlen-1:0]       mem_pc4,
    input  logic [rv_pkg::xlen-1:0]       dmem_rdata,
    output logic                          dmem_req,
    output logic                          dmem_we,
    output logic [rv_pkg::xlen-1:0]       dmem_addr,
    output logic [rv_pkg::xlen-1:0]       dmem_wdata,
    output logic                          wb_en,
    output logic [rv_pkg::reg_addr_w-1:0] wb_addr,
    output logic [rv_pkg::xlen-1:0]       wb_data,
    hazard_if.mem_src                     haz
);
    import rv_pkg::*;

    wb_sel_e         wb_sel;
    logic [xlen-1:0] load_q;
    logic [xlen-1:0] alu_q;
    logic [xlen-1:0] pc4_q;

    function automatic logic [xlen-1:0] wb_pick(
        input wb_sel_e         sel,
        input logic [xlen-1:0] load,
        input logic [xlen-1:0] alu,
        input logic [xlen-1:0] pc4
    );
        case (sel)
            wb_mem:  return load;
            wb_pc4:  return pc4;
            default: return alu;
        endcase
    endfunction

    // Word accesses only, address from the ALU
    assign dmem_req   = (mem_opcode == op_load) || (mem_opcode == op_store);
    assign dmem_we    = (mem_opcode == op_store);
    assign dmem_addr  = mem_result_alu;
    assign dmem_wdata = mem_store_data;

    assign haz.mem_rd     = mem_rd;
    assign haz.mem_wr_en  = mem_wr_en;
    assign haz.mem_result = wb_pick(mem_wb_sel, dmem_rdata, mem_result_alu, mem_pc4);

    // MEM/WB control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en   <= 1'b0;
            wb_addr <= '0;
            wb_sel  <= wb_alu;
        end else begin
            wb_en   <= mem_wr_en;
            wb_addr <= mem_rd;
            wb_sel  <= mem_wb_sel;
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk) begin
        load_q <= dmem_rdata;
        alu_q  <= mem_result_alu;
        pc4_q  <= mem_pc4;
    end

    assign wb_data = wb_pick(wb_sel, load_q, alu_q, pc4_q);

    a_we_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n) dmem_we |-> dmem_req
    );

    // A store reaching WB never writes the register file
    a_store_no_writeback: assert property (
        @(posedge clk) disable iff (!arst_n) dmem_we |=> !wb_en
    );

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    input  logic                          wb_en,
    input  logic [rv_pkg::reg_addr_w-1:0] wb_addr,
    input  logic [rv_pkg::xlen-1:0]       wb_data,
    output logic [rv_pkg::xlen-1:0]       rf_rdata1,
    output logic [rv_pkg::xlen-1:0]       rf_rdata2
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [1 << reg_addr_w];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // x0 reads zero, WB write bypasses to ID in the same cycle
    assign rf_rdata1 = (rs1 == '0) ? '0 :
                       (wb_en && wb_addr == rs1) ? wb_data : regs[rs1];
    assign rf_rdata2 = (rs2 == '0) ? '0 :
                       (wb_en && wb_addr == rs2) ? wb_data : regs[rs2];

endmodule

`default_nettype wire

/* src/rv_core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_top (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  logic [rv_pkg::xlen-1:0] imem_data,
    output logic                    dmem_req,
    output logic                    dmem_we,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata
);
    import rv_pkg::*;

    // Hazard control
    logic            stall;
    logic            flush;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    logic            take_branch;
    logic [xlen-1:0] branch_target;

    // IF/ID and register file read side
    logic [xlen-1:0]       id_pc;
    logic [xlen-1:0]       id_instr;
    opcode_e               id_opcode;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       rf_rdata1;
    logic [xlen-1:0]       rf_rdata2;

    // ID/EX
    logic [xlen-1:0]       ex_pc;
    logic [xlen-1:0]       ex_a;
    logic [xlen-1:0]       ex_b;
    logic [xlen-1:0]       ex_imm;
    logic [reg_addr_w-1:0] ex_rd;
    alu_op_e               ex_alu_op;
    opcode_e               ex_opcode;
    wb_sel_e               ex_wb_sel;
    logic                  ex_wr_en;
    logic                  ex_use_imm;
    logic [xlen-1:0]       ex_store_data;

    // EX/MEM
    logic [xlen-1:0]       mem_result_alu;
    logic [xlen-1:0]       mem_store_data;
    logic [reg_addr_w-1:0] mem_rd;
    opcode_e               mem_opcode;
    wb_sel_e               mem_wb_sel;
    logic                  mem_wr_en;
    logic [xlen-1:0]       mem_pc4;

    // Register file write port from MEM/WB
    logic                  wb_en;
    logic [reg_addr_w-1:0] wb_addr;
    logic [xlen-1:0]       wb_data;

    hazard_if haz ();

    // Opcode of the ID instruction for load-use detection
    assign id_opcode = opcode_e'(id_instr[6:0]);

    fetch_stage fetch_stage_inst (.*);

    decode_stage decode_stage_inst (.*);

    reg_file reg_file_inst (.*);

    hazard_unit hazard_unit_inst (.*);

    execute_stage execute_stage_inst (.*);

    mem_wb_stage mem_wb_stage_inst (.*);

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // ADDI x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    // Major opcodes as encoded in the instruction word
    typedef enum logic [6:0] {
        op_rtype  = 7'b0110011,
        op_itype  = 7'b0010011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_ex,
        fwd_mem
    } fwd_sel_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4
    } wb_sel_e;

endpackage

`default_nettype wire

/* tb.f */
src/rv_pkg.sv
src/hazard_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/hazard_unit.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/rv_core_top.sv
dv/tb_checker.sv
dv/tb_top.sv
